//--- armController.f
common/armCtrlPkg.sv
common/decodeBus.sv
common/execBus.sv
decode/instrDecoder.sv
execute/condCheck.sv
execute/executeControl.sv
hdl/memWbControl.sv
hdl/armController.sv
bench/armController_sva.sv
bench/armControllerTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Compile and run the armController testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module armControllerTb \
  -f armController.f -o armControllerSim > build.log 2>&1 \
  && ./obj_dir/armControllerSim > sim.log 2>&1 \
  || echo "Build or run stopped early, see build.log and sim.log"

grep -q "SIMULATION PASSED" sim.log 2>/dev/null && echo "Run passed" && exit 0 \
  || { echo "Run failed"; exit 1; }

//--- bench/armControllerTb.sv
`timescale 1ns/1ns
`default_nettype none

module armControllerTb;

  // ====================
  // Run sizes
  // ====================
  localparam int ResetCycles = 10;
  localparam int TableLen    = 24;
  localparam int RandomRows  = 40;
  localparam int DrainRows   = 5;
  localparam int StallCycles = 3;
  localparam int TotalRows   = TableLen + RandomRows + DrainRows;
  localparam int CycleLimit  = 2 * TotalRows + ResetCycles + StallCycles + DrainRows;

  // aluFlags and addrLow belong to the instruction sitting in Execute
  typedef struct packed {
    logic [31:0] instr;
    logic [3:0]  aluFlags;  // NZCV
    logic [1:0]  addrLow;
    logic        stall;     // All three stages together
    logic        flush;     // flushE
  } rowT;

  // Expected controls of one instruction as it moves down the pipe
  typedef struct packed {
    logic [1:0]           regSrc;
    logic [1:0]           immSrc;
    logic                 aluSrc;
    armCtrlPkg::aluOpT    aluOp;
    logic [1:0]           flagWrite;
    logic                 branch;
    logic                 memWrite;
    logic                 regWrite;
    logic                 memtoReg;
    logic                 pcSrc;       // Ungated
    logic                 byteAccess;
    logic                 noWrite;
    armCtrlPkg::condT     cond;
    logic                 fresh;       // Not yet evaluated in Execute
    logic                 branchT;
    logic                 memWriteG;
    logic                 regWriteG;
    logic                 memtoRegG;
    logic                 pcSrcG;
    logic                 setFlags;
    armCtrlPkg::byteMaskT mask;
    armCtrlPkg::flagsT    flagsNext;
  } stageT;

  rowT stimTable [TableLen] = '{
    {32'hE3B01000, 4'b0000, 2'd0, 1'b0, 1'b0},  // MOVS r1,#0
    {32'h02822001, 4'b0100, 2'd0, 1'b0, 1'b0},  // ADDEQ, Z from MOVS
    {32'hE2533001, 4'b0000, 2'd0, 1'b0, 1'b0},  // SUBS
    {32'h12844001, 4'b1010, 2'd0, 1'b0, 1'b0},  // ADDNE, N and C from SUBS
    {32'hE3510005, 4'b0000, 2'd0, 1'b0, 1'b0},  // CMP r1,#5
    {32'h0A000004, 4'b0110, 2'd0, 1'b0, 1'b0},  // BEQ, Z and C from CMP
    {32'h1A000004, 4'b0000, 2'd0, 1'b0, 1'b0},  // BNE
    {32'hE5810004, 4'b0000, 2'd0, 1'b0, 1'b0},  // STR
    {32'hE5C10005, 4'b0000, 2'd0, 1'b0, 1'b0},  // STRB
    {32'hE5512003, 4'b0000, 2'd1, 1'b0, 1'b0},  // LDRB, STRB on lane 1
    {32'hE591F000, 4'b0000, 2'd3, 1'b0, 1'b0},  // LDR pc, LDRB on lane 3
    {32'hE3110001, 4'b0000, 2'd0, 1'b0, 1'b0},  // TSTS
    {32'h41A0F000, 4'b1000, 2'd0, 1'b0, 1'b0},  // MOVMI pc, N from TSTS
    {32'hE0912003, 4'b0000, 2'd0, 1'b0, 1'b0},  // ADDS register form
    {32'hE5C10006, 4'b0001, 2'd0, 1'b0, 1'b0},  // STRB, V from ADDS
    {32'hE5810004, 4'b0000, 2'd2, 1'b1, 1'b0},  // Stall with STRB in E
    {32'hE5810004, 4'b0000, 2'd2, 1'b1, 1'b0},
    {32'hE5810004, 4'b0000, 2'd2, 1'b1, 1'b0},
    {32'hE5810004, 4'b0000, 2'd2, 1'b0, 1'b0},  // Released
    {32'hE5C10007, 4'b0000, 2'd0, 1'b0, 1'b1},  // STRB flushed to a bubble
    {32'hE3A00001, 4'b0000, 2'd0, 1'b0, 1'b0},  // MOV r0,#1
    {32'hE2900001, 4'b0000, 2'd0, 1'b0, 1'b0},  // ADDS
    {32'hD3A0F000, 4'b0101, 2'd0, 1'b0, 1'b0},  // MOVLE pc, forwarded Z
    {32'hE1A00000, 4'b0000, 2'd0, 1'b0, 1'b0}   // MOV r0,r0
  };

  logic                 clk;
  logic                 reset;
  armCtrlPkg::instrT    instrD;
  armCtrlPkg::flagsT    aluFlagsE;
  logic [1:0]           aluAddrLowE;
  logic                 stallE;
  logic                 flushE;
  logic                 stallM;
  logic                 stallW;
  logic                 flushW;
  logic [1:0]           regSrcD;
  logic [1:0]           immSrcD;
  logic                 aluSrcE;
  armCtrlPkg::aluOpT    aluControlE;
  logic                 branchTakenE;
  logic                 memWriteM;
  armCtrlPkg::byteMaskT byteMaskM;
  logic                 regWriteW;
  logic                 memtoRegW;
  logic                 pcSrcW;
  armCtrlPkg::flagsT    statusFlags;
  logic                 pcWrPendingF;

  // Reference pipeline, one slot per stage
  stageT             dRec;
  stageT             eRec;
  stageT             mRec;
  stageT             wRec;
  armCtrlPkg::flagsT specFlags;    // Flags after everything up to Execute
  armCtrlPkg::flagsT modelStatus;  // Retired flags
  logic              prevStall;
  logic              prevFlush;
  int                cycleCount = 0;

  armController u_dut (
    .clk(clk), .reset(reset), .instrD(instrD), .aluFlagsE(aluFlagsE),
    .aluAddrLowE(aluAddrLowE), .stallE(stallE), .flushE(flushE), .stallM(stallM),
    .stallW(stallW), .flushW(flushW), .regSrcD(regSrcD), .immSrcD(immSrcD),
    .aluSrcE(aluSrcE), .aluControlE(aluControlE), .branchTakenE(branchTakenE),
    .memWriteM(memWriteM), .byteMaskM(byteMaskM), .regWriteW(regWriteW),
    .memtoRegW(memtoRegW), .pcSrcW(pcSrcW), .statusFlags(statusFlags),
    .pcWrPendingF(pcWrPendingF)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;  // 40 ns period

  // Run limit
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("Timeout: test still running after %0d cycles", CycleLimit);
      $display("SIMULATION FAILED");
      $fatal(1, "Cycle limit reached");
    end
  end

  // ====================
  // Compare tasks
  // ====================
  task automatic reportMismatch(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1, "Output mismatch");
  endtask

  task automatic checkBit(input string what, input logic got, input logic exp);
    if (got !== exp) reportMismatch($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  task automatic checkSelect(input string what, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) reportMismatch($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  task automatic checkAluOp(input string what, input armCtrlPkg::aluOpT got,
                            input armCtrlPkg::aluOpT exp);
    if (got !== exp)
      reportMismatch($sformatf("%s is %s, expected %s", what, got.name(), exp.name()));
  endtask

  task automatic checkMask(input string what, input armCtrlPkg::byteMaskT got,
                           input armCtrlPkg::byteMaskT exp);
    if (got !== exp) reportMismatch($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  task automatic checkFlags(input string what, input armCtrlPkg::flagsT got,
                            input armCtrlPkg::flagsT exp);
    if (got !== exp) reportMismatch($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  // ====================
  // Reference model
  // ====================
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic stageT bubble();
    stageT r;
    r = '0;
    r.fresh = 1'b1;  // Still passes through Execute
    return r;
  endfunction

  // Class rules straight from the instruction fields
  function automatic stageT decodeExpect(input logic [31:0] ins);
    stageT      r;
    logic [3:0] op;
    logic       arith;
    r     = bubble();
    op    = ins[24:21];
    arith = ((op >= 4'h2) && (op <= 4'h7)) || (op == 4'hA) || (op == 4'hB);
    r.cond  = armCtrlPkg::condT'(ins[31:28]);
    r.aluOp = armCtrlPkg::aluAdd;
    case (ins[27:26])
      2'b00: begin
        r.aluSrc    = ins[25];
        r.aluOp     = armCtrlPkg::aluOpT'(op);
        r.regWrite  = 1'b1;
        r.noWrite   = (op >= 4'h8) && (op <= 4'hB);  // TST TEQ CMP CMN
        r.flagWrite = {ins[20], ins[20] & arith};
      end
      2'b01: begin
        r.regSrc     = {~ins[20], 1'b0};
        r.immSrc     = 2'b01;
        r.aluSrc     = ~ins[25];
        r.aluOp      = ins[23] ? armCtrlPkg::aluAdd : armCtrlPkg::aluSub;  // U bit
        r.regWrite   = ins[20];
        r.memWrite   = ~ins[20];
        r.memtoReg   = ins[20];
        r.byteAccess = ins[22];
      end
      2'b10: begin
        if (ins[25]) begin
          r.regSrc = 2'b01;
          r.immSrc = 2'b10;
          r.aluSrc = 1'b1;
          r.branch = 1'b1;
        end
      end
      default: begin
      end
    endcase
    r.pcSrc = r.branch | (r.regWrite & ~r.noWrite & (ins[15:12] == 4'hF));
    return r;
  endfunction

  function automatic logic condHolds(input logic [3:0] c, input armCtrlPkg::flagsT f);
    case (c)
      4'h0:    condHolds = f.z;
      4'h1:    condHolds = !f.z;
      4'h2:    condHolds = f.c;
      4'h3:    condHolds = !f.c;
      4'h4:    condHolds = f.n;
      4'h5:    condHolds = !f.n;
      4'h6:    condHolds = f.v;
      4'h7:    condHolds = !f.v;
      4'h8:    condHolds = f.c && !f.z;
      4'h9:    condHolds = !f.c || f.z;
      4'hA:    condHolds = (f.n == f.v);
      4'hB:    condHolds = (f.n != f.v);
      4'hC:    condHolds = !f.z && (f.n == f.v);
      4'hD:    condHolds = f.z || (f.n != f.v);
      4'hE:    condHolds = 1'b1;
      default: condHolds = 1'b0;  // NV
    endcase
  endfunction

  // Resolve the Execute slot once, on its first cycle there
  task automatic evaluateExecute(input armCtrlPkg::flagsT alu, input logic [1:0] addrLow);
    logic pass;
    if (eRec.fresh) begin
      pass            = condHolds(eRec.cond, specFlags);
      eRec.branchT    = eRec.branch & pass;
      eRec.memWriteG  = eRec.memWrite & pass;
      eRec.regWriteG  = eRec.regWrite & pass & ~eRec.noWrite;
      eRec.memtoRegG  = eRec.memtoReg & pass;
      eRec.pcSrcG     = eRec.pcSrc & pass;
      eRec.mask       = eRec.byteAccess ? (4'b0001 << addrLow) : 4'b1111;
      eRec.flagsNext  = specFlags;
      if (eRec.flagWrite[1]) begin
        eRec.flagsNext.n = alu.n;
        eRec.flagsNext.z = alu.z;
      end
      if (eRec.flagWrite[0]) begin  // Arithmetic only
        eRec.flagsNext.c = alu.c;
        eRec.flagsNext.v = alu.v;
      end
      eRec.setFlags = (eRec.flagWrite != 2'b00) & pass;
      if (eRec.setFlags) specFlags = eRec.flagsNext;
      eRec.fresh = 1'b0;
    end
  endtask

  // Mirrors the clock edge that just passed
  task automatic advancePipeline();
    if (!prevStall) begin
      if (wRec.setFlags) modelStatus = wRec.flagsNext;
      wRec = mRec;
      mRec = eRec;
      eRec = prevFlush ? bubble() : dRec;
    end
  endtask

  task automatic checkRegistered();
    checkBit("aluSrcE", aluSrcE, eRec.aluSrc);
    checkAluOp("aluControlE", aluControlE, eRec.aluOp);
    checkBit("memWriteM", memWriteM, mRec.memWriteG);
    checkMask("byteMaskM", byteMaskM, mRec.mask);
    checkBit("regWriteW", regWriteW, wRec.regWriteG);
    checkBit("memtoRegW", memtoRegW, wRec.memtoRegG);
    checkBit("pcSrcW", pcSrcW, wRec.pcSrcG);
    checkFlags("statusFlags", statusFlags, modelStatus);
  endtask

  task automatic checkCombinational();
    checkSelect("regSrcD", regSrcD, dRec.regSrc);
    checkSelect("immSrcD", immSrcD, dRec.immSrc);
    checkBit("branchTakenE", branchTakenE, eRec.branchT);
    checkBit("pcWrPendingF", pcWrPendingF, dRec.pcSrc | eRec.pcSrc | mRec.pcSrcG);
  endtask

  // ====================
  // Stimulus
  // ====================
  initial begin
    int          i;
    int          pick;
    rowT         cur;
    logic [31:0] rnd;
    instrD      = '0;
    aluFlagsE   = '0;
    aluAddrLowE = 2'd0;
    stallE      = 1'b0;
    flushE      = 1'b0;
    stallM      = 1'b0;
    stallW      = 1'b0;
    flushW      = 1'b0;
    reset       = 1'b1;
    rnd         = 32'd98;  // Seed
    eRec        = bubble();  // Reset leaves Execute empty
    mRec        = '0;
    wRec        = '0;
    dRec        = '0;
    specFlags   = '0;
    modelStatus = '0;
    prevStall   = 1'b0;
    prevFlush   = 1'b0;
    repeat (ResetCycles) @(negedge clk);
    reset = 1'b0;

    for (i = 0; i < TotalRows; i++) begin
      if (i > 0) begin
        @(negedge clk);
        advancePipeline();
      end
      if (i < TableLen) begin
        cur = stimTable[i];
      end else if (i < TableLen + RandomRows) begin
        rnd = xorshift(rnd);
        pick = int'(rnd % 32'(TableLen));
        cur = stimTable[pick];
        cur.instr[31:28] = rnd[31:28];  // Random condition
        cur.aluFlags     = rnd[7:4];
        cur.addrLow      = rnd[9:8];
        cur.stall        = 1'b0;
        cur.flush        = 1'b0;
      end else begin
        cur = {32'hF0000000, 4'b0000, 2'd0, 1'b0, 1'b0};  // Never-executed drain
      end

      checkRegistered();  // Stable since the rising edge
      evaluateExecute(cur.aluFlags, cur.addrLow);
      instrD      = cur.instr;
      aluFlagsE   = cur.aluFlags;
      aluAddrLowE = cur.addrLow;
      stallE      = cur.stall;
      stallM      = cur.stall;
      stallW      = cur.stall;
      flushE      = cur.flush;
      dRec        = decodeExpect(cur.instr);
      #1;
      checkCombinational();
      prevStall = cur.stall;
      prevFlush = cur.flush;
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/armController_sva.sv
`timescale 1ns/1ns
`default_nettype none

module armController_sva (
  input logic                 clk,
  input logic                 reset,
  input logic                 stallM,
  input logic                 regWriteW,
  input logic                 memWriteM,
  input armCtrlPkg::byteMaskT byteMaskM,
  input logic                 branchTakenE,
  input logic                 pcWrPendingF
);

  // Writeback cleared by reset
  regWriteClearedAfterReset: assert property (@(posedge clk) reset |=> !regWriteW)
    else $error("regWriteW high in the cycle after reset");

  // A store enables the whole word or exactly one lane
  storeHasLanes: assert property (@(posedge clk) disable iff (reset)
    memWriteM |-> ((byteMaskM == armCtrlPkg::fullWordMask) || $onehot(byteMaskM)))
    else $error("memWriteM with a byte mask that is neither a word nor one lane");

  // Taken branch stays a pending PC write once it reaches Memory
  branchMarksPcWrite: assert property (@(posedge clk) disable iff (reset)
    (branchTakenE && !stallM) |=> pcWrPendingF)
    else $error("taken branch not pending a PC write in Memory");

endmodule

bind armController armController_sva uSva (
  .clk          (clk),
  .reset        (reset),
  .stallM       (stallM),
  .regWriteW    (regWriteW),
  .memWriteM    (memWriteM),
  .byteMaskM    (byteMaskM),
  .branchTakenE (branchTakenE),
  .pcWrPendingF (pcWrPendingF)
);

`default_nettype wire

//--- hdl/armController.sv
`timescale 1ns/1ns
`default_nettype none

module armController (
  // Clock and reset
  input  logic                 clk,
  input  logic                 reset,
  // From datapath
  input  armCtrlPkg::instrT    instrD,
  input  armCtrlPkg::flagsT    aluFlagsE,
  input  logic [1:0]           aluAddrLowE,   // ALU result [1:0]
  // From hazard unit
  input  logic                 stallE,
  input  logic                 flushE,
  input  logic                 stallM,
  input  logic                 stallW,
  input  logic                 flushW,
  // To datapath
  output logic [1:0]           regSrcD,
  output logic [1:0]           immSrcD,
  output logic                 aluSrcE,
  output armCtrlPkg::aluOpT    aluControlE,
  output logic                 branchTakenE,
  output logic                 memWriteM,
  output armCtrlPkg::byteMaskT byteMaskM,
  output logic                 regWriteW,
  output logic                 memtoRegW,
  output logic                 pcSrcW,
  output armCtrlPkg::flagsT    statusFlags,
  // To hazard unit
  output logic                 pcWrPendingF
);

  logic              pcSrcD;
  logic              pcSrcE;   // Ungated, still in flight
  logic              pcSrcM;
  armCtrlPkg::flagsT flagsE;   // Forwarded flags for the condition check

  decodeBus decBus ();
  execBus   exBus ();

  // ====================
  // Decode
  // ====================
  instrDecoder uDecoder (
    .instrD  (instrD),
    .regSrcD (regSrcD),
    .immSrcD (immSrcD),
    .pcSrcD  (pcSrcD),
    .dec     (decBus.decode)
  );

  // ====================
  // Execute
  // ====================
  executeControl uExecute (
    .clk          (clk),
    .reset        (reset),
    .stallE       (stallE),
    .flushE       (flushE),
    .flagsE       (flagsE),
    .aluFlagsE    (aluFlagsE),
    .aluAddrLowE  (aluAddrLowE),
    .dec          (decBus.execute),
    .aluSrcE      (aluSrcE),
    .aluControlE  (aluControlE),
    .branchTakenE (branchTakenE),
    .pcSrcE       (pcSrcE),
    .ex           (exBus.execute)
  );

  // ====================
  // Memory and writeback
  // ====================
  memWbControl uMemWb (
    .clk         (clk),
    .reset       (reset),
    .stallM      (stallM),
    .stallW      (stallW),
    .flushW      (flushW),
    .ex          (exBus.memWb),
    .memWriteM   (memWriteM),
    .byteMaskM   (byteMaskM),
    .pcSrcM      (pcSrcM),
    .regWriteW   (regWriteW),
    .memtoRegW   (memtoRegW),
    .pcSrcW      (pcSrcW),
    .flagsE      (flagsE),
    .statusFlags (statusFlags)
  );

  // PC may be rewritten by something still in D, E or M
  assign pcWrPendingF = pcSrcD | pcSrcE | pcSrcM;

endmodule

`default_nettype wire

//--- hdl/memWbControl.sv
`timescale 1ns/1ns
`default_nettype none

module memWbControl (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 stallM,
  input  logic                 stallW,
  input  logic                 flushW,
  execBus.memWb                ex,
  output logic                 memWriteM,
  output armCtrlPkg::byteMaskT byteMaskM,
  output logic                 pcSrcM,
  output logic                 regWriteW,
  output logic                 memtoRegW,
  output logic                 pcSrcW,
  output armCtrlPkg::flagsT    flagsE,       // Forwarded to Execute
  output armCtrlPkg::flagsT    statusFlags   // Architectural NZCV
);

  logic              regWriteM;
  logic              memtoRegM;
  logic              setFlagsM;
  logic              setFlagsW;
  armCtrlPkg::flagsT flagsNextM;
  armCtrlPkg::flagsT flagsNextW;

  // ====================
  // Memory register
  // ====================
  always_ff @(posedge clk) begin
    if (reset) begin
      memWriteM <= 1'b0;
      byteMaskM <= '0;
      regWriteM <= 1'b0;
      memtoRegM <= 1'b0;
      pcSrcM    <= 1'b0;
      setFlagsM <= 1'b0;
    end else if (!stallM) begin
      memWriteM <= ex.memWrite;
      byteMaskM <= ex.byteMask;
      regWriteM <= ex.regWrite;
      memtoRegM <= ex.memtoReg;
      pcSrcM    <= ex.pcSrc;
      setFlagsM <= ex.setFlags;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallM) flagsNextM <= ex.flagsNext;  // Qualified by setFlagsM
  end

  // ====================
  // Writeback register
  // ====================
  always_ff @(posedge clk) begin
    if (reset || (flushW && !stallW)) begin
      regWriteW <= 1'b0;
      memtoRegW <= 1'b0;
      pcSrcW    <= 1'b0;
      setFlagsW <= 1'b0;
    end else if (!stallW) begin
      regWriteW <= regWriteM;
      memtoRegW <= memtoRegM;
      pcSrcW    <= pcSrcM;
      setFlagsW <= setFlagsM;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallW) flagsNextW <= flagsNextM;
  end

  // Status register, updated as Writeback retires
  always_ff @(posedge clk) begin
    if (reset) statusFlags <= '0;
    else if (setFlagsW && !stallW) statusFlags <= flagsNextW;
  end

  // Youngest flag writer wins
  assign flagsE = setFlagsM ? flagsNextM :
                  setFlagsW ? flagsNextW : statusFlags;

endmodule

`default_nettype wire

//--- execute/executeControl.sv
`timescale 1ns/1ns
`default_nettype none

module executeControl (
  input  logic              clk,
  input  logic              reset,
  input  logic              stallE,
  input  logic              flushE,
  input  armCtrlPkg::flagsT flagsE,       // Forwarded current flags
  input  armCtrlPkg::flagsT aluFlagsE,
  input  logic [1:0]        aluAddrLowE,  // Address byte offset
  decodeBus.execute         dec,
  output logic              aluSrcE,
  output armCtrlPkg::aluOpT aluControlE,
  output logic              branchTakenE,
  output logic              pcSrcE,
  execBus.execute           ex
);

  logic              branchE;
  logic              memWriteE;
  logic              regWriteE;
  logic              memtoRegE;
  logic              byteAccessE;
  logic              noRegWriteE;
  logic [1:0]        flagWriteE;
  armCtrlPkg::condT  condE;
  logic              condExE;      // Condition passed
  armCtrlPkg::flagsT flagsNextE;

  // ====================
  // Execute register
  // ====================
  always_ff @(posedge clk) begin
    if (reset || (flushE && !stallE)) begin  // Bubble, all controls low
      aluSrcE     <= 1'b0;
      aluControlE <= armCtrlPkg::aluAnd;
      flagWriteE  <= 2'b00;
      branchE     <= 1'b0;
      memWriteE   <= 1'b0;
      regWriteE   <= 1'b0;
      memtoRegE   <= 1'b0;
      pcSrcE      <= 1'b0;
      byteAccessE <= 1'b0;
      condE       <= armCtrlPkg::condEq;
      noRegWriteE <= 1'b0;
    end else if (!stallE) begin
      aluSrcE     <= dec.aluSrc;
      aluControlE <= dec.aluControl;
      flagWriteE  <= dec.flagWrite;
      branchE     <= dec.branch;
      memWriteE   <= dec.memWrite;
      regWriteE   <= dec.regWrite;
      memtoRegE   <= dec.memtoReg;
      pcSrcE      <= dec.pcSrc;
      byteAccessE <= dec.byteAccess;
      condE       <= dec.cond;
      noRegWriteE <= dec.noRegWrite;
    end
  end

  // ====================
  // Condition check
  // ====================
  condCheck uCond (
    .cond      (condE),
    .flags     (flagsE),
    .aluFlags  (aluFlagsE),
    .flagWrite (flagWriteE),
    .condEx    (condExE),
    .flagsNext (flagsNextE)
  );

  // Every side effect waits on the condition
  assign branchTakenE = branchE & condExE;
  assign ex.memWrite  = memWriteE & condExE;
  assign ex.regWrite  = regWriteE & condExE & ~noRegWriteE;  // CMP etc. never write Rd
  assign ex.memtoReg  = memtoRegE & condExE;
  assign ex.pcSrc     = pcSrcE & condExE;
  assign ex.setFlags  = (flagWriteE != 2'b00) & condExE;
  assign ex.flagsNext = flagsNextE;

  // Byte lane from offset, else whole word
  assign ex.byteMask = byteAccessE ? armCtrlPkg::byteMaskT'(4'b0001 << aluAddrLowE)
                                   : armCtrlPkg::fullWordMask;

endmodule

`default_nettype wire

//--- execute/condCheck.sv
`timescale 1ns/1ns
`default_nettype none

module condCheck (
  input  armCtrlPkg::condT  cond,
  input  armCtrlPkg::flagsT flags,      // Flags before this instruction
  input  armCtrlPkg::flagsT aluFlags,
  input  logic [1:0]        flagWrite,  // {NZ, CV}
  output logic              condEx,
  output armCtrlPkg::flagsT flagsNext
);

  logic nEqV;  // Signed compare helper

  assign nEqV = (flags.n == flags.v);

  // ARM condition table
  always_comb begin
    case (cond)
      armCtrlPkg::condEq: condEx = flags.z;
      armCtrlPkg::condNe: condEx = ~flags.z;
      armCtrlPkg::condCs: condEx = flags.c;
      armCtrlPkg::condCc: condEx = ~flags.c;
      armCtrlPkg::condMi: condEx = flags.n;
      armCtrlPkg::condPl: condEx = ~flags.n;
      armCtrlPkg::condVs: condEx = flags.v;
      armCtrlPkg::condVc: condEx = ~flags.v;
      armCtrlPkg::condHi: condEx = flags.c & ~flags.z;   // Unsigned higher
      armCtrlPkg::condLs: condEx = ~flags.c | flags.z;
      armCtrlPkg::condGe: condEx = nEqV;
      armCtrlPkg::condLt: condEx = ~nEqV;
      armCtrlPkg::condGt: condEx = ~flags.z & nEqV;
      armCtrlPkg::condLe: condEx = flags.z | ~nEqV;
      armCtrlPkg::condAl: condEx = 1'b1;
      default:            condEx = 1'b0;                 // NV, never
    endcase
  end

  // Merge new flags per group
  always_comb begin
    flagsNext = flags;
    if (flagWrite[1]) begin
      flagsNext.n = aluFlags.n;
      flagsNext.z = aluFlags.z;
    end
    if (flagWrite[0]) begin  // Logical ops leave C and V alone
      flagsNext.c = aluFlags.c;
      flagsNext.v = aluFlags.v;
    end
  end

endmodule

`default_nettype wire

//--- decode/instrDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
  input  armCtrlPkg::instrT instrD,
  output logic [1:0]        regSrcD,   // [1] Rd on port 2, [0] PC on port 1
  output logic [1:0]        immSrcD,   // 00 imm8 rot, 01 imm12, 10 imm24
  output logic              pcSrcD,
  decodeBus.decode          dec
);

  logic [3:0] opField;   // instr[24:21]
  logic       immForm;   // I bit
  logic       sBit;
  logic       upBit;     // U bit, add or subtract offset
  logic       loadBit;   // L bit
  logic       rdIsPc;

  assign opField = instrD[24:21];
  assign immForm = instrD[25];
  assign sBit    = instrD[20];
  assign upBit   = instrD[23];
  assign loadBit = instrD[20];
  assign rdIsPc  = (instrD[15:12] == armCtrlPkg::pcRegIndex);

  assign dec.cond = armCtrlPkg::condT'(instrD[31:28]);

  // ====================
  // Main decoder
  // ====================
  always_comb begin
    // Unknown classes do nothing and add
    regSrcD        = 2'b00;
    immSrcD        = 2'b00;
    dec.aluSrc     = 1'b0;
    dec.aluControl = armCtrlPkg::aluAdd;
    dec.flagWrite  = 2'b00;
    dec.branch     = 1'b0;
    dec.memWrite   = 1'b0;
    dec.regWrite   = 1'b0;
    dec.memtoReg   = 1'b0;
    dec.byteAccess = 1'b0;
    dec.noRegWrite = 1'b0;

    case (instrD[27:26])
      armCtrlPkg::opClassDp: begin
        immSrcD        = 2'b00;
        dec.aluSrc     = immForm;                          // Register or rotated imm8
        dec.aluControl = armCtrlPkg::aluOpT'(opField);
        // NZ on any S op, CV only for arithmetic
        dec.flagWrite  = {sBit, sBit & armCtrlPkg::arithOpSet[opField]};
        dec.regWrite   = 1'b1;
        dec.noRegWrite = armCtrlPkg::noWriteOpSet[opField]; // Compare and test
      end
      armCtrlPkg::opClassMem: begin
        regSrcD        = {~loadBit, 1'b0};  // Store data read from Rd
        immSrcD        = 2'b01;
        dec.aluSrc     = ~immForm;          // I clear means imm12 offset
        dec.aluControl = upBit ? armCtrlPkg::aluAdd : armCtrlPkg::aluSub;
        dec.regWrite   = loadBit;
        dec.memWrite   = ~loadBit;
        dec.memtoReg   = loadBit;
        dec.byteAccess = instrD[22];        // B bit
      end
      armCtrlPkg::opClassBranch: begin
        if (immForm) begin                  // B, block transfers not handled
          regSrcD    = 2'b01;               // Base is PC
          immSrcD    = 2'b10;
          dec.aluSrc = 1'b1;
          dec.branch = 1'b1;
        end
      end
      default: begin
        // Coprocessor and SWI space, left as a no-op
      end
    endcase
  end

  // Branches and real writes to R15 redirect fetch
  assign pcSrcD    = dec.branch | (dec.regWrite & ~dec.noRegWrite & rdIsPc);
  assign dec.pcSrc = pcSrcD;

endmodule

`default_nettype wire

//--- common/execBus.sv
`timescale 1ns/1ns
`default_nettype none

// Condition-gated controls, Execute to Memory
interface execBus;
  logic                  memWrite;
  logic                  regWrite;
  logic                  memtoReg;
  logic                  pcSrc;
  armCtrlPkg::byteMaskT  byteMask;   // Lane enables from address offset
  armCtrlPkg::flagsT     flagsNext;  // Merged NZCV
  logic                  setFlags;   // S bit and condition passed

  modport execute (output memWrite, regWrite, memtoReg, pcSrc,
                   byteMask, flagsNext, setFlags);
  modport memWb (input memWrite, regWrite, memtoReg, pcSrc,
                 byteMask, flagsNext, setFlags);
endinterface

`default_nettype wire

//--- common/decodeBus.sv
`timescale 1ns/1ns
`default_nettype none

// Decoded controls, Decode to Execute
interface decodeBus;
  logic                aluSrc;      // Immediate operand B
  armCtrlPkg::aluOpT   aluControl;
  logic [1:0]          flagWrite;   // {NZ, CV}
  logic                branch;
  logic                memWrite;
  logic                regWrite;
  logic                memtoReg;
  logic                pcSrc;       // Writes R15 or branches
  logic                byteAccess;  // LDRB/STRB
  armCtrlPkg::condT    cond;
  logic                noRegWrite;  // TST/TEQ/CMP/CMN

  modport decode (output aluSrc, aluControl, flagWrite, branch, memWrite, regWrite,
                  memtoReg, pcSrc, byteAccess, cond, noRegWrite);
  modport execute (input aluSrc, aluControl, flagWrite, branch, memWrite, regWrite,
                   memtoReg, pcSrc, byteAccess, cond, noRegWrite);
endinterface

`default_nettype wire

//--- common/armCtrlPkg.sv
`default_nettype none

package armCtrlPkg;

  // ====================
  // Basic types
  // ====================

  typedef logic [31:0] instrT;      // Raw instruction word
  typedef logic [3:0]  byteMaskT;   // One enable per byte lane

  // Data-processing opcode, instr[24:21]
  typedef enum logic [3:0] {
    aluAnd = 4'h0,
    aluEor = 4'h1,
    aluSub = 4'h2,
    aluRsb = 4'h3,
    aluAdd = 4'h4,
    aluAdc = 4'h5,
    aluSbc = 4'h6,
    aluRsc = 4'h7,
    aluTst = 4'h8,
    aluTeq = 4'h9,
    aluCmp = 4'hA,
    aluCmn = 4'hB,
    aluOrr = 4'hC,
    aluMov = 4'hD,
    aluBic = 4'hE,
    aluMvn = 4'hF
  } aluOpT;

  // Condition field, instr[31:28]
  typedef enum logic [3:0] {
    condEq = 4'h0, condNe = 4'h1, condCs = 4'h2, condCc = 4'h3,
    condMi = 4'h4, condPl = 4'h5, condVs = 4'h6, condVc = 4'h7,
    condHi = 4'h8, condLs = 4'h9, condGe = 4'hA, condLt = 4'hB,
    condGt = 4'hC, condLe = 4'hD, condAl = 4'hE, condNv = 4'hF
  } condT;

  // NZCV, n is the MSB
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // ====================
  // Encodings
  // ====================

  localparam logic [1:0] opClassDp     = 2'b00;  // instr[27:26]
  localparam logic [1:0] opClassMem    = 2'b01;  // LDR/STR
  localparam logic [1:0] opClassBranch = 2'b10;  // B when instr[25] set

  localparam logic [3:0] pcRegIndex   = 4'd15;    // R15 as destination
  localparam byteMaskT   fullWordMask = 4'b1111;

  // Ops whose S form also updates C and V
  localparam logic [15:0] arithOpSet =
    (16'b1 << aluAdd) | (16'b1 << aluSub) | (16'b1 << aluRsb) | (16'b1 << aluAdc) |
    (16'b1 << aluSbc) | (16'b1 << aluRsc) | (16'b1 << aluCmp) | (16'b1 << aluCmn);

  // Compare and test, flags only
  localparam logic [15:0] noWriteOpSet =
    (16'b1 << aluTst) | (16'b1 << aluTeq) | (16'b1 << aluCmp) | (16'b1 << aluCmn);

endpackage

`default_nettype wire
